// File: list.f
+incdir+.
mdu_pkg.sv
mdu_mul.sv
mdu_div.sv
mdu_core.sv
tb_mdu.sv

// File: Makefile
# Verilator build and run for the multiply/divide unit testbench

VERILATOR ?= verilator
TOP       ?= tb_mdu
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard *.sv *.svh)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail, not the simulator exit status
run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_mdu_ref.svh
// --------------------
// Testbench reference model of the RISC-V M extension
// Galois LFSR step for random stimulus
// --------------------
`ifndef TB_MDU_REF_SVH
`define TB_MDU_REF_SVH

`include "mdu_defs.svh"

// Expected rd, computed with 64-bit arithmetic
function automatic logic [`MDU_XLEN-1:0] mdu_ref(input mdu_pkg::mdu_op_e op,
                                                  input logic [`MDU_XLEN-1:0] a,
                                                  input logic [`MDU_XLEN-1:0] b);
    logic signed [2*`MDU_XLEN-1:0] sa;
    logic signed [2*`MDU_XLEN-1:0] sb;
    logic signed [2*`MDU_XLEN-1:0] ua;
    logic signed [2*`MDU_XLEN-1:0] ub;
    logic signed [2*`MDU_XLEN-1:0] wide;
    sa = {{`MDU_XLEN{a[`MDU_XLEN-1]}}, a};
    sb = {{`MDU_XLEN{b[`MDU_XLEN-1]}}, b};
    ua = {{`MDU_XLEN{1'b0}}, a};
    ub = {{`MDU_XLEN{1'b0}}, b};
    // Every true product fits in 64 bits, so the upper half is exact
    case (op)
        mdu_pkg::op_mul:    wide = sa * sb;
        mdu_pkg::op_mulh:   wide = (sa * sb) >>> `MDU_XLEN;
        mdu_pkg::op_mulhsu: wide = (sa * ub) >>> `MDU_XLEN;
        mdu_pkg::op_mulhu:  wide = (ua * ub) >> `MDU_XLEN;
        mdu_pkg::op_div:    wide = sa / sb;
        mdu_pkg::op_divu:   wide = ua / ub;
        mdu_pkg::op_rem:    wide = sa % sb;   // Sign follows the dividend
        default:            wide = ua % ub;
    endcase
    if (b == '0) begin
        // Divide by zero: quotient all ones, remainder is the dividend
        if (op == mdu_pkg::op_div || op == mdu_pkg::op_divu) wide = '1;
        if (op == mdu_pkg::op_rem || op == mdu_pkg::op_remu) wide = ua;
    end
    return wide[`MDU_XLEN-1:0];
endfunction

// One step of a 32-bit Galois LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

`endif

// File: tb_mdu.sv
// --------------------
// Testbench for the multiply/divide unit
// Directed corners, random sweep, hold, flush and clock request
// --------------------
`timescale 1ns/100ps
`include "mdu_defs.svh"

module tb_mdu;

    localparam int n_random    = 400;
    localparam int n_ops       = 2 * 4 * 25 + n_random + 8;
    localparam int ready_bound = `MDU_XLEN + 4;

    logic                 g_clk;
    logic                 rst_n;
    logic                 flush;
    logic                 valid;
    mdu_pkg::mdu_op_e     op;
    logic [`MDU_XLEN-1:0] rs1;
    logic [`MDU_XLEN-1:0] rs2;
    logic                 ready;
    logic [`MDU_XLEN-1:0] rd;
    logic                 clk_req;

    logic [31:0]          lfsr_state = 32'ha7a6_00dd;
    logic [31:0]          corners [5] = '{32'h0, 32'h1, 32'hffff_ffff,
                                          32'h8000_0000, 32'h7fff_ffff};

    // Check request served by the checker process
    string                chk_name;
    logic [31:0]          chk_exp;
    logic [31:0]          chk_got;
    int                   chk_seq = 0;
    int                   chk_ack = 0;
    int                   n_checks = 0;

    `include "tb_mdu_ref.svh"

    mdu_core #(.mul_unroll(`MDU_MUL_UNROLL)) DUT (
        .g_clk(g_clk), .rst_n(rst_n), .flush(flush), .valid(valid), .op(op),
        .rs1(rs1), .rs2(rs2), .ready(ready), .rd(rd), .clk_req(clk_req)
    );

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;
    end

    // --------------------
    // Checker
    always @(chk_seq) begin
        assert (chk_got === chk_exp) begin
            n_checks++;
            chk_ack = chk_seq;
        end else begin
            $display("FAIL %s expected %08h actual %08h", chk_name, chk_exp, chk_got);
            $display("TEST FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        chk_name = name;
        chk_exp  = exp;
        chk_got  = got;
        chk_seq++;
        wait (chk_ack == chk_seq);
    endtask

    // Shifts in one LFSR bit per step
    task automatic take_bits(input int n, output logic [31:0] w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            w          = {w[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // --------------------
    // One operation entered and left on a falling edge
    task automatic run_op(input string test, input mdu_pkg::mdu_op_e o,
                          input logic [31:0] a, input logic [31:0] b, input int hold);
        logic [31:0] exp;
        int          waited;
        string       tag;
        exp    = mdu_ref(o, a, b);
        tag    = $sformatf("%s %s %08h %08h", test, o.name(), a, b);
        waited = 0;
        valid  = 1'b1;
        op     = o;
        rs1    = a;
        rs2    = b;
        do begin
            @(negedge g_clk);
            waited++;
            check_value({tag, " clk_req"}, 32'd1, {31'd0, clk_req});
            assert (waited <= ready_bound) else begin
                $display("Timeout: ready did not rise within %0d cycles for %s",
                         ready_bound, tag);
                $display("TEST FAILED");
                $fatal(1, "No result from the DUT");
            end
        end while (!ready);
        check_value({tag, " rd"}, exp, rd);
        repeat (hold) begin     // Valid kept high past ready
            @(negedge g_clk);
            check_value({tag, " hold ready"}, 32'd1, {31'd0, ready});
            check_value({tag, " hold rd"}, exp, rd);
            check_value({tag, " hold clk_req"}, 32'd1, {31'd0, clk_req});
        end
        valid = 1'b0;
        @(negedge g_clk);
        check_value({tag, " idle clk_req"}, 32'd0, {31'd0, clk_req});
        check_value({tag, " idle ready"}, 32'd0, {31'd0, ready});
    endtask

    // Abort after some cycles with flush and valid falling together
    task automatic flush_op(input string test, input mdu_pkg::mdu_op_e o,
                            input logic [31:0] a, input logic [31:0] b, input int cycles);
        valid = 1'b1;
        op    = o;
        rs1   = a;
        rs2   = b;
        repeat (cycles) begin
            @(negedge g_clk);
            check_value({test, " busy ready"}, 32'd0, {31'd0, ready});
            check_value({test, " busy clk_req"}, 32'd1, {31'd0, clk_req});
        end
        valid = 1'b0;
        flush = 1'b1;
        @(negedge g_clk);
        check_value({test, " ready after flush"}, 32'd0, {31'd0, ready});
        check_value({test, " clk_req on flush"}, 32'd1, {31'd0, clk_req});
        flush = 1'b0;
        repeat (ready_bound) begin  // An aborted operation would have finished here
            @(negedge g_clk);
            check_value({test, " ready after flush"}, 32'd0, {31'd0, ready});
            check_value({test, " idle clk_req"}, 32'd0, {31'd0, clk_req});
        end
    endtask

    // --------------------
    // Main sequence
    initial begin
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      w;
        mdu_pkg::mdu_op_e o;
        rst_n = 1'b0;
        flush = 1'b0;
        valid = 1'b0;
        op    = mdu_pkg::op_mul;
        rs1   = '0;
        rs2   = '0;
        repeat (8) @(negedge g_clk);
        rst_n = 1'b1;
        @(negedge g_clk);
        check_value("reset ready", 32'd0, {31'd0, ready});
        check_value("reset clk_req", 32'd0, {31'd0, clk_req});

        for (int k = 0; k < 8; k++) begin   // Multiply ops first and divide ops after
            o = mdu_pkg::mdu_op_e'(k[2:0]);
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    run_op(k < 4 ? "mul_corner" : "div_corner", o, corners[i], corners[j], 0);
                end
            end
        end

        for (int n = 0; n < n_random; n++) begin
            take_bits(3, w);
            o = mdu_pkg::mdu_op_e'(w[2:0]);
            take_bits(32, a);
            take_bits(32, b);
            run_op("random", o, a, b, 0);
        end

        run_op("hold", mdu_pkg::op_divu, 32'hdead_beef, 32'h0000_1234, 5);

        flush_op("flush_div", mdu_pkg::op_div, 32'h1234_5678, 32'h0000_0123, 15);
        run_op("after_flush", mdu_pkg::op_rem, 32'hfedc_ba98, 32'h0000_0777, 0);
        flush_op("flush_mul", mdu_pkg::op_mulh, 32'h8765_4321, 32'hcafe_f00d, 5);
        run_op("after_flush", mdu_pkg::op_mulhsu, 32'h9abc_def0, 32'h1357_9bdf, 0);

        if (n_checks > 0) begin
            $display("TEST OK");
        end else begin
            $display("No checks were executed");
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog sized from the operation count
    initial begin
        repeat (8 + n_ops * (`MDU_XLEN + 8)) @(posedge g_clk);
        $display("Timeout: the run did not finish in %0d cycles",
                 8 + n_ops * (`MDU_XLEN + 8));
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: mdu_core.sv
// --------------------
// MDU top level
// Routes the opcode to multiplier or divider, selects the result
// --------------------
`timescale 1ns/100ps
`include "mdu_defs.svh"

module mdu_core #(
    parameter int mul_unroll = `MDU_MUL_UNROLL
) (
    input  logic                 g_clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 valid,
    input  mdu_pkg::mdu_op_e     op,
    input  logic [`MDU_XLEN-1:0] rs1,
    input  logic [`MDU_XLEN-1:0] rs2,
    output logic                 ready,
    output logic [`MDU_XLEN-1:0] rd,
    output logic                 clk_req
);

    logic                 is_mul;
    logic                 is_div;
    logic                 mul_start;
    logic                 div_start;
    logic                 mul_done;
    logic                 div_done;
    logic [`MDU_XLEN-1:0] mul_result;
    logic [`MDU_XLEN-1:0] div_result;

    // Opcode class decode
    always_comb begin
        is_mul = 1'b0;
        is_div = 1'b0;
        case (op)
            mdu_pkg::op_mul, mdu_pkg::op_mulh,
            mdu_pkg::op_mulhsu, mdu_pkg::op_mulhu: is_mul = 1'b1;
            default:                               is_div = 1'b1;
        endcase
    end

    assign mul_start = valid & is_mul;
    assign div_start = valid & is_div;

    mdu_mul #(.mul_unroll(mul_unroll)) u_mul (
        .g_clk(g_clk), .rst_n(rst_n), .flush(flush), .start(mul_start), .op(op),
        .rs1(rs1), .rs2(rs2), .done(mul_done), .result(mul_result)
    );

    mdu_div u_div (
        .g_clk(g_clk), .rst_n(rst_n), .flush(flush), .start(div_start), .op(op),
        .rs1(rs1), .rs2(rs2), .done(div_done), .result(div_result)
    );

    assign rd      = is_mul ? mul_result : div_result;
    assign ready   = (is_mul & mul_done) | (is_div & div_done);
    assign clk_req = valid | flush;     // Clock only needed with work pending

endmodule

// File: mdu_div.sv
// --------------------
// Restoring divider, one quotient bit per cycle
// Works on magnitudes, sign fixed at the output
// --------------------
`timescale 1ns/100ps
`include "mdu_defs.svh"

module mdu_div (
    input  logic                 g_clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 start,
    input  mdu_pkg::mdu_op_e     op,
    input  logic [`MDU_XLEN-1:0] rs1,
    input  logic [`MDU_XLEN-1:0] rs2,
    output logic                 done,
    output logic [`MDU_XLEN-1:0] result
);

    localparam int xlen = `MDU_XLEN;

    mdu_pkg::mdu_seq_e      seq;
    logic [`MDU_CTR_W-1:0]  ctr;
    logic [xlen-1:0]        raw_a;      // Operands as received
    logic [xlen-1:0]        raw_b;
    logic [xlen-1:0]        dividend;   // Ends up as the remainder
    logic [2*xlen-1:0]      divisor;
    logic [xlen-1:0]        quotient;

    logic                   div_signed;
    logic                   want_quot;
    logic                   sign_a;
    logic                   sign_b;
    logic                   out_neg;
    logic                   fits;
    logic [xlen-1:0]        qmask;
    logic [xlen-1:0]        mag_a;
    logic [xlen-1:0]        mag_b;
    logic [xlen-1:0]        div_out;

    assign div_signed = (op == mdu_pkg::op_div) || (op == mdu_pkg::op_rem);
    assign want_quot  = (op == mdu_pkg::op_div) || (op == mdu_pkg::op_divu);

    assign sign_a = div_signed & raw_a[xlen-1];
    assign sign_b = div_signed & raw_b[xlen-1];
    assign mag_a  = sign_a ? -raw_a : raw_a;
    assign mag_b  = sign_b ? -raw_b : raw_b;

    // Quotient forced positive on divide by zero, remainder follows dividend
    assign out_neg = want_quot ? ((sign_a ^ sign_b) & (|raw_b)) : sign_a;

    assign fits  = divisor <= {{xlen{1'b0}}, dividend};
    assign qmask = {{(xlen-1){1'b0}}, 1'b1} << (ctr - 1'b1);

    // --------------------
    // Sequencer
    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            seq <= mdu_pkg::seq_idle;
            ctr <= '0;
        end else if (flush) begin
            seq <= mdu_pkg::seq_idle;
            ctr <= '0;
        end else begin
            case (seq)
                mdu_pkg::seq_idle: if (start) seq <= mdu_pkg::seq_load;
                mdu_pkg::seq_load: begin
                    seq <= mdu_pkg::seq_run;
                    ctr <= `MDU_CTR_W'(xlen);
                end
                mdu_pkg::seq_run: begin
                    if (ctr != 0) ctr <= ctr - 1'b1;
                    else          seq <= mdu_pkg::seq_done;
                end
                mdu_pkg::seq_done: if (!start) seq <= mdu_pkg::seq_idle;
                default: seq <= mdu_pkg::seq_idle;
            endcase
        end
    end

    // --------------------
    // Datapath registers
    always_ff @(posedge g_clk) begin
        case (seq)
            mdu_pkg::seq_idle: begin
                if (start) begin
                    raw_a <= rs1;
                    raw_b <= rs2;
                end
            end
            mdu_pkg::seq_load: begin
                dividend <= mag_a;
                divisor  <= {{xlen{1'b0}}, mag_b} << (xlen - 1);   // Aligned to quotient MSB
                quotient <= '0;
            end
            mdu_pkg::seq_run: begin
                if (ctr != 0) begin
                    if (fits) begin
                        dividend <= dividend - divisor[xlen-1:0];
                        quotient <= quotient | qmask;
                    end
                    divisor <= divisor >> 1;
                end
            end
            default: begin
            end
        endcase
    end

    assign div_out = want_quot ? quotient : dividend;
    assign result  = out_neg ? -div_out : div_out;
    assign done    = (seq == mdu_pkg::seq_done);

endmodule

// File: mdu_mul.sv
// --------------------
// Iterative shift-and-add multiplier
// Retires mul_unroll bits per cycle into a 2*XLEN accumulator
// --------------------
`timescale 1ns/100ps
`include "mdu_defs.svh"

module mdu_mul #(
    parameter int mul_unroll = `MDU_MUL_UNROLL
) (
    input  logic                 g_clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 start,
    input  mdu_pkg::mdu_op_e     op,
    input  logic [`MDU_XLEN-1:0] rs1,
    input  logic [`MDU_XLEN-1:0] rs2,
    output logic                 done,
    output logic [`MDU_XLEN-1:0] result
);

    localparam int xlen = `MDU_XLEN;
    localparam logic [`MDU_CTR_W-1:0] steps = `MDU_CTR_W'(xlen / mul_unroll);

    mdu_pkg::mdu_seq_e      seq;
    logic [`MDU_CTR_W-1:0]  ctr;        // Steps left to retire
    logic [xlen-1:0]        mcand;      // Multiplicand, held
    logic [xlen-1:0]        mplier;     // Shifted down each step
    logic [2*xlen-1:0]      acc;
    logic [2*xlen-1:0]      acc_n;

    logic                   lhs_signed;
    logic                   rhs_signed;
    logic                   sub_last;
    logic [xlen-1:0]        to_add;
    logic [xlen:0]          add_l;
    logic [xlen:0]          add_r;
    logic [xlen:0]          sum;

    // MULH is signed x signed, MULHSU signed x unsigned
    assign lhs_signed = (op == mdu_pkg::op_mulh) || (op == mdu_pkg::op_mulhsu);
    assign rhs_signed = (op == mdu_pkg::op_mulh);

    // --------------------
    // One step, mul_unroll partial products
    always_comb begin
        acc_n    = acc;
        sub_last = 1'b0;
        to_add   = '0;
        add_l    = '0;
        add_r    = '0;
        sum      = '0;
        for (int i = 0; i < mul_unroll; i++) begin
            // Top bit of a signed multiplier has negative weight
            sub_last = (i == mul_unroll - 1) && (ctr == 1) && rhs_signed && mplier[i];
            to_add   = mplier[i] ? mcand : '0;
            add_l    = {lhs_signed & acc_n[2*xlen-1], acc_n[2*xlen-1:xlen]};
            add_r    = {lhs_signed & to_add[xlen-1], to_add};
            if (sub_last) begin
                add_r = ~add_r;
            end
            sum   = add_l + add_r + {{xlen{1'b0}}, sub_last};
            acc_n = {sum, acc_n[xlen-1:1]};
        end
    end

    // --------------------
    // Sequencer
    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            seq <= mdu_pkg::seq_idle;
            ctr <= '0;
        end else if (flush) begin
            seq <= mdu_pkg::seq_idle;
            ctr <= '0;
        end else begin
            case (seq)
                mdu_pkg::seq_idle: begin
                    if (start) begin
                        seq <= mdu_pkg::seq_run;
                        ctr <= steps;
                    end
                end
                mdu_pkg::seq_run: begin
                    if (ctr != 0) ctr <= ctr - 1'b1;
                    else          seq <= mdu_pkg::seq_done;
                end
                mdu_pkg::seq_done: if (!start) seq <= mdu_pkg::seq_idle;  // Hold while start
                default: seq <= mdu_pkg::seq_idle;
            endcase
        end
    end

    // Operands and accumulator
    always_ff @(posedge g_clk) begin
        if (seq == mdu_pkg::seq_idle && start) begin
            mcand  <= rs1;
            mplier <= rs2;
            acc    <= '0;
        end else if (seq == mdu_pkg::seq_run && ctr != 0) begin
            mplier <= mplier >> mul_unroll;
            acc    <= acc_n;
        end
    end

    assign done   = (seq == mdu_pkg::seq_done);
    assign result = (op == mdu_pkg::op_mul) ? acc[xlen-1:0] : acc[2*xlen-1:xlen];

endmodule

// File: mdu_pkg.sv
// --------------------
// Opcode and sequencer state types for the MDU
// --------------------
package mdu_pkg;

    // Follows funct3 of the M extension
    typedef enum logic [2:0] {
        op_mul    = 3'b000,
        op_mulh   = 3'b001,
        op_mulhsu = 3'b010,
        op_mulhu  = 3'b011,
        op_div    = 3'b100,
        op_divu   = 3'b101,
        op_rem    = 3'b110,
        op_remu   = 3'b111
    } mdu_op_e;

    // Datapath sequence of both multiplier and divider
    typedef enum logic [1:0] {
        seq_idle = 2'd0,
        seq_load = 2'd1,    // Divider only, magnitude setup
        seq_run  = 2'd2,
        seq_done = 2'd3
    } mdu_seq_e;

endpackage

// File: mdu_defs.svh
// --------------------
// Widths and defaults for the multiply/divide unit
// --------------------
`ifndef MDU_DEFS_SVH
`define MDU_DEFS_SVH

// Data word width
`define MDU_XLEN        32

// Multiplier bits retired per cycle, one of 1, 2, 4 or 8
`define MDU_MUL_UNROLL  4

// Iteration counter, must hold XLEN
`define MDU_CTR_W       7

`endif
